//--- logic/redmule_cfg_pkg.sv
package redmule_cfg_pkg;

  // Accumulator array is ARRAY_N x ARRAY_N
  localparam int unsigned ARRAY_N = 4;

  // Row index width inside the array
  localparam int unsigned ROW_W = $clog2(ARRAY_N);

  // Signed operand element
  localparam int unsigned ELEM_W = 8;

  // One input stream word carries a full operand vector
  localparam int unsigned WORD_W = ARRAY_N * ELEM_W;

  // Signed accumulator and result element
  localparam int unsigned ACC_W = 24;

  // Product of two operand elements before widening
  localparam int unsigned PROD_W = 2 * ELEM_W;

  // Depth field in the command word, steps minus one
  localparam int unsigned DEPTH_W = 8;

  // Remaining bits of the command word
  localparam int unsigned CMD_RSVD_W = WORD_W - DEPTH_W;

  // Default operand FIFO depth, in pairs
  localparam int unsigned FIFO_DEPTH = 4;

endpackage : redmule_cfg_pkg

//--- logic/redmule_stream_pkg.sv
package redmule_stream_pkg;

  import redmule_cfg_pkg::*;

  // One signed operand element
  typedef logic signed [ELEM_W-1:0] elem_t;

  // A row of W or a column of X, one input data word
  typedef elem_t [ARRAY_N-1:0] elem_vec_t;

  // Command view of an input word
  typedef struct packed {
    logic [CMD_RSVD_W-1:0] reserved;
    logic [DEPTH_W-1:0]    depth_m1;
  } cmd_t;

  // Input word, read as command or data by the decoder phase
  typedef union packed {
    elem_vec_t data;
    cmd_t      cmd;
  } stream_word_u;

  // Accumulator and result element
  typedef logic signed [ACC_W-1:0] acc_t;

  // One result row
  typedef acc_t [ARRAY_N-1:0] z_row_t;

  // Operands of one rank-1 step
  typedef struct packed {
    elem_vec_t x_col;
    elem_vec_t w_row;
    logic      last;
  } operand_pair_t;

  // Bias row write into the accumulators
  typedef struct packed {
    logic             en;
    logic [ROW_W-1:0] row;
    elem_vec_t        data;
  } bias_wr_t;

  // One beat on the result stream
  typedef struct packed {
    z_row_t row;
    logic   last;
  } z_beat_t;

endpackage : redmule_stream_pkg

//--- logic/redmule_stream_decoder.sv
`timescale 1ns/100ps

module redmule_stream_decoder (
  input  logic                             clk_i      ,
  input  logic                             rst_n_i    ,
  input  logic                             in_valid_i ,
  input  redmule_stream_pkg::stream_word_u in_word_i  ,
  input  logic                             fifo_full_i,
  input  logic                             job_done_i ,
  output logic                             in_ready_o ,
  output logic                             push_o     ,
  output redmule_stream_pkg::operand_pair_t pair_o    ,
  output redmule_stream_pkg::bias_wr_t     bias_o     ,
  output logic                             busy_o
);

  import redmule_cfg_pkg::*;
  import redmule_stream_pkg::*;

  typedef enum logic [1:0] {IDLE, BIAS, OPS, WAIT} phase_e;

  phase_e             phase_q;
  logic               accept;
  logic [ROW_W-1:0]   row_cnt_q;
  logic [DEPTH_W-1:0] step_cnt_q;
  // Next word in OPS is an X column when set
  logic               want_x_q;
  logic               bias_en_q;
  logic [ROW_W-1:0]   bias_row_q;
  elem_vec_t          bias_data_q;
  logic               push_q;
  elem_vec_t          w_row_q;
  elem_vec_t          x_col_q;
  logic               last_q;

  always_comb begin
    case (phase_q)
      IDLE:    in_ready_o = 1'b1;
      BIAS:    in_ready_o = 1'b1;
      OPS:     in_ready_o = ~fifo_full_i;
      default: in_ready_o = 1'b0;
    endcase
  end

  assign accept = in_valid_i & in_ready_o;
  assign busy_o = (phase_q != IDLE);

  // Phase machine and counters
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      phase_q    <= IDLE;
      row_cnt_q  <= '0;
      step_cnt_q <= '0;
      want_x_q   <= 1'b0;
      bias_en_q  <= 1'b0;
      push_q     <= 1'b0;
    end else begin
      bias_en_q <= accept && (phase_q == BIAS);
      push_q    <= accept && (phase_q == OPS) && want_x_q;
      case (phase_q)
        IDLE: begin
          if (accept) begin
            step_cnt_q <= in_word_i.cmd.depth_m1;
            row_cnt_q  <= '0;
            want_x_q   <= 1'b0;
            phase_q    <= BIAS;
          end
        end
        BIAS: begin
          if (accept) begin
            row_cnt_q <= row_cnt_q + 1'b1;
            if (row_cnt_q == ROW_W'(ARRAY_N - 1)) begin
              phase_q <= OPS;
            end
          end
        end
        OPS: begin
          if (accept) begin
            want_x_q <= ~want_x_q;
            if (want_x_q) begin
              step_cnt_q <= step_cnt_q - 1'b1;
              // Last X column closes the job's input
              if (step_cnt_q == '0) begin
                phase_q <= WAIT;
              end
            end
          end
        end
        default: begin
          if (job_done_i) begin
            phase_q <= IDLE;
          end
        end
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (accept && (phase_q == BIAS)) begin
      bias_row_q  <= row_cnt_q;
      bias_data_q <= in_word_i.data;
    end
    if (accept && (phase_q == OPS)) begin
      if (want_x_q) begin
        x_col_q <= in_word_i.data;
        last_q  <= (step_cnt_q == '0);
      end else begin
        w_row_q <= in_word_i.data;
      end
    end
  end

  assign bias_o = '{en: bias_en_q, row: bias_row_q, data: bias_data_q};
  assign push_o = push_q;
  assign pair_o = '{x_col: x_col_q, w_row: w_row_q, last: last_q};

endmodule : redmule_stream_decoder

//--- logic/redmule_operand_fifo.sv
`timescale 1ns/100ps

module redmule_operand_fifo #(
  parameter int unsigned Depth = 4
) (
  input  logic                              clk_i      ,
  input  logic                              rst_n_i    ,
  input  logic                              push_i     ,
  input  redmule_stream_pkg::operand_pair_t pair_i     ,
  input  logic                              pop_i      ,
  output logic                              full_o     ,
  output logic                              not_empty_o,
  output redmule_stream_pkg::operand_pair_t head_o
);

  import redmule_stream_pkg::*;

  localparam int unsigned PtrW = $clog2(Depth);
  localparam int unsigned CntW = $clog2(Depth + 1);

  operand_pair_t   mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && not_empty_o;

  // Pointers wrap explicitly so any depth works
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= pair_i;
    end
  end

  assign full_o      = (count_q == CntW'(Depth));
  assign not_empty_o = (count_q != '0);
  // Show-ahead head
  assign head_o      = mem_q[rd_ptr_q];

endmodule : redmule_operand_fifo

//--- logic/redmule_engine.sv
`timescale 1ns/100ps

module redmule_engine (
  input  logic                                                      clk_i           ,
  input  logic                                                      rst_n_i         ,
  input  redmule_stream_pkg::bias_wr_t                              bias_i          ,
  input  logic                                                      fifo_not_empty_i,
  input  redmule_stream_pkg::operand_pair_t                         head_i          ,
  input  logic                                                      z_free_i        ,
  output logic                                                      pop_o           ,
  output logic                                                      load_o          ,
  output redmule_stream_pkg::z_row_t [redmule_cfg_pkg::ARRAY_N-1:0] z_matrix_o
);

  import redmule_cfg_pkg::*;
  import redmule_stream_pkg::*;

  z_row_t [ARRAY_N-1:0] acc_q;
  z_row_t [ARRAY_N-1:0] acc_d;
  // Result complete, waiting for the Z buffer
  logic                 hold_q;

  assign pop_o  = fifo_not_empty_i && !hold_q;
  assign load_o = hold_q && z_free_i;

  always_comb begin
    logic signed [PROD_W-1:0] prod;
    prod  = '0;
    acc_d = acc_q;
    // Bias row load, Y sign-extended to accumulator width
    if (bias_i.en) begin
      for (int j = 0; j < ARRAY_N; j++) begin
        acc_d[bias_i.row][j] = {{(ACC_W - ELEM_W){bias_i.data[j][ELEM_W-1]}},
                                bias_i.data[j]};
      end
    end
    // Rank-1 update, wraps modulo 2^ACC_W
    if (pop_o) begin
      for (int i = 0; i < ARRAY_N; i++) begin
        for (int j = 0; j < ARRAY_N; j++) begin
          prod = $signed(head_i.x_col[i]) * $signed(head_i.w_row[j]);
          acc_d[i][j] = acc_q[i][j] + {{(ACC_W - PROD_W){prod[PROD_W-1]}}, prod};
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    acc_q <= acc_d;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      hold_q <= 1'b0;
    end else begin
      if (pop_o && head_i.last) begin
        hold_q <= 1'b1;
      end else if (load_o) begin
        hold_q <= 1'b0;
      end
    end
  end

  assign z_matrix_o = acc_q;

endmodule : redmule_engine

//--- logic/redmule_z_buffer.sv
`timescale 1ns/100ps

module redmule_z_buffer (
  input  logic                                                      clk_i     ,
  input  logic                                                      rst_n_i   ,
  input  logic                                                      load_i    ,
  input  redmule_stream_pkg::z_row_t [redmule_cfg_pkg::ARRAY_N-1:0] z_matrix_i,
  input  logic                                                      z_ready_i ,
  output logic                                                      z_free_o  ,
  output logic                                                      z_valid_o ,
  output redmule_stream_pkg::z_beat_t                               z_beat_o
);

  import redmule_cfg_pkg::*;
  import redmule_stream_pkg::*;

  z_row_t [ARRAY_N-1:0] mat_q;
  logic [ROW_W-1:0]     row_idx_q;
  logic                 full_q;
  logic                 last_row;
  logic                 xfer;

  assign last_row = (row_idx_q == ROW_W'(ARRAY_N - 1));
  assign xfer     = full_q && z_ready_i;

  // Row index and occupancy
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q    <= 1'b0;
      row_idx_q <= '0;
    end else begin
      if (load_i) begin
        full_q    <= 1'b1;
        row_idx_q <= '0;
      end else if (xfer) begin
        row_idx_q <= row_idx_q + 1'b1;
        // Free again once the final row has left
        if (last_row) begin
          full_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      mat_q <= z_matrix_i;
    end
  end

  assign z_free_o  = !full_q;
  assign z_valid_o = full_q;
  assign z_beat_o  = '{row: mat_q[row_idx_q], last: last_row};

endmodule : redmule_z_buffer

//--- logic/redmule_top.sv
`timescale 1ns/100ps

module redmule_top #(
  parameter int unsigned FifoDepth = redmule_cfg_pkg::FIFO_DEPTH
) (
  input  logic                             clk_i     ,
  input  logic                             rst_n_i   ,
  input  logic                             in_valid_i,
  input  redmule_stream_pkg::stream_word_u in_word_i ,
  input  logic                             z_ready_i ,
  output logic                             in_ready_o,
  output logic                             busy_o    ,
  output logic                             z_valid_o ,
  output redmule_stream_pkg::z_beat_t      z_beat_o
);

  import redmule_cfg_pkg::*;
  import redmule_stream_pkg::*;

  logic                 push;
  operand_pair_t        push_pair;
  bias_wr_t             bias_wr;
  logic                 fifo_full;
  logic                 fifo_not_empty;
  operand_pair_t        fifo_head;
  logic                 pop;
  // Engine load doubles as job done for the decoder
  logic                 load;
  logic                 z_free;
  z_row_t [ARRAY_N-1:0] z_matrix;

  redmule_stream_decoder i_decoder (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .in_valid_i  ( in_valid_i ),
    .in_word_i   ( in_word_i  ),
    .fifo_full_i ( fifo_full  ),
    .job_done_i  ( load       ),
    .in_ready_o  ( in_ready_o ),
    .push_o      ( push       ),
    .pair_o      ( push_pair  ),
    .bias_o      ( bias_wr    ),
    .busy_o      ( busy_o     )
  );

  redmule_operand_fifo #(
    .Depth       ( FifoDepth      )
  ) i_w_fifo (
    .clk_i       ( clk_i          ),
    .rst_n_i     ( rst_n_i        ),
    .push_i      ( push           ),
    .pair_i      ( push_pair      ),
    .pop_i       ( pop            ),
    .full_o      ( fifo_full      ),
    .not_empty_o ( fifo_not_empty ),
    .head_o      ( fifo_head      )
  );

  redmule_engine i_engine (
    .clk_i            ( clk_i          ),
    .rst_n_i          ( rst_n_i        ),
    .bias_i           ( bias_wr        ),
    .fifo_not_empty_i ( fifo_not_empty ),
    .head_i           ( fifo_head      ),
    .z_free_i         ( z_free         ),
    .pop_o            ( pop            ),
    .load_o           ( load           ),
    .z_matrix_o       ( z_matrix       )
  );

  redmule_z_buffer i_z_buffer (
    .clk_i      ( clk_i     ),
    .rst_n_i    ( rst_n_i   ),
    .load_i     ( load      ),
    .z_matrix_i ( z_matrix  ),
    .z_ready_i  ( z_ready_i ),
    .z_free_o   ( z_free    ),
    .z_valid_o  ( z_valid_o ),
    .z_beat_o   ( z_beat_o  )
  );

endmodule : redmule_top

//--- verif/redmule_tb_clkgen.sv
`timescale 1ns/100ps

module redmule_tb_clkgen #(
  parameter int unsigned HalfPeriodNs = 5,
  parameter int unsigned ResetCycles  = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HalfPeriodNs) clk_o = ~clk_o;
    end
  end

  // Release 1 ns after the last reset edge
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule : redmule_tb_clkgen

//--- verif/redmule_tb.sv
`timescale 1ns/100ps

module redmule_tb;

  import redmule_cfg_pkg::*;
  import redmule_stream_pkg::*;

  localparam logic [31:0] LfsrSeed     = 32'hc6f6;
  localparam int unsigned NumJobs      = 7;
  localparam int unsigned MarginCycles = 2000;

  typedef enum logic [1:0] {READY_ALWAYS, READY_LFSR, READY_HOLD} ready_mode_e;

  typedef struct packed {
    logic [DEPTH_W-1:0] depth_m1;
    logic               use_lfsr;
    ready_mode_e        ready_mode;
    z_row_t             row0;
  } job_t;

  typedef z_row_t [ARRAY_N-1:0] z_mat_t;

  logic         clk;
  logic         rst_n;
  logic         in_valid;
  stream_word_u in_word;
  logic         z_ready;
  logic         in_ready;
  logic         busy;
  logic         z_valid;
  z_beat_t      z_beat;
  z_mat_t       exp_q [$];
  logic [31:0]  data_lfsr;
  logic [31:0]  ready_lfsr;
  int unsigned  jobs_sent;
  int unsigned  rows_seen;
  int unsigned  limit_cycles;

  // Fixed operands reused on every step
  // Fixed bias Y[i][j] is 16*i+j
  elem_t fix_x [ARRAY_N] = '{8'sd3, -8'sd1, 8'sd2, 8'sd5};
  elem_t fix_w [ARRAY_N] = '{8'sd2, -8'sd3, 8'sd4, -8'sd5};

  // Row 0 values are listed from column 3 down to column 0
  job_t jobs [NumJobs] = '{
    '{8'd0,   1'b0, READY_ALWAYS, {-24'sd12, 24'sd14, -24'sd8, 24'sd6}},
    '{8'd0,   1'b1, READY_ALWAYS, '0},
    '{8'd6,   1'b1, READY_LFSR,   '0},
    '{8'd63,  1'b1, READY_HOLD,   '0},
    '{8'd255, 1'b1, READY_LFSR,   '0},
    '{8'd255, 1'b0, READY_HOLD,   {-24'sd3837, 24'sd3074, -24'sd2303, 24'sd1536}},
    '{8'd6,   1'b1, READY_ALWAYS, '0}
  };

  redmule_tb_clkgen i_clkgen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  redmule_top #(
    .FifoDepth  ( FIFO_DEPTH )
  ) uut (
    .clk_i      ( clk      ),
    .rst_n_i    ( rst_n    ),
    .in_valid_i ( in_valid ),
    .in_word_i  ( in_word  ),
    .z_ready_i  ( z_ready  ),
    .in_ready_o ( in_ready ),
    .busy_o     ( busy     ),
    .z_valid_o  ( z_valid  ),
    .z_beat_o   ( z_beat   )
  );

  // Polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic elem_t pick_elem(input logic use_lfsr, input elem_t fixed);
    elem_t e;
    e = fixed;
    if (use_lfsr) begin
      for (int b = 0; b < ELEM_W; b++) begin
        data_lfsr = galois_step(data_lfsr);
        e = {e[ELEM_W-2:0], data_lfsr[0]};
      end
    end
    return e;
  endfunction

  function automatic int unsigned watchdog_cycles();
    int unsigned total;
    total = MarginCycles;
    for (int k = 0; k < NumJobs; k++) begin
      total += (2 * ARRAY_N + 2 * (jobs[k].depth_m1 + 1)) * 20;
    end
    return total;
  endfunction

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_row(input z_row_t got, input z_row_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("mismatch at %0t: %s, got %h expected %h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("mismatch at %0t: %s, got %b expected %b",
                                  $time, what, got, exp));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Holds the word until in_ready_o is seen high before an edge
  task automatic send_word(input stream_word_u word, input logic is_cmd,
                           input logic prev_hold);
    logic taken;
    taken    = 1'b0;
    in_valid = 1'b1;
    in_word  = word;
    while (!taken) begin
      #2;
      taken = in_ready;
      if (taken && is_cmd) begin
        check_flag(busy, 1'b0, "busy_o when a command is taken");
        if (prev_hold) begin
          check_flag(z_valid, 1'b1, "z_valid_o of the stalled job at next command");
        end
      end
      next_cycle();
    end
    in_valid = 1'b0;
  endtask

  task automatic drive_job(input int k);
    z_mat_t       model;
    stream_word_u word;
    elem_vec_t    w_row;
    elem_vec_t    x_col;
    word = '0;
    word.cmd.depth_m1 = jobs[k].depth_m1;
    send_word(word, 1'b1, (k > 0) && (jobs[k-1].ready_mode == READY_HOLD));
    check_flag(busy, 1'b1, "busy_o the cycle after a command");
    for (int i = 0; i < ARRAY_N; i++) begin
      for (int j = 0; j < ARRAY_N; j++) begin
        word.data[j] = pick_elem(jobs[k].use_lfsr, elem_t'(16 * i + j));
        model[i][j]  = acc_t'(int'(word.data[j]));
      end
      send_word(word, 1'b0, 1'b0);
    end
    for (int s = 0; s <= int'(jobs[k].depth_m1); s++) begin
      for (int j = 0; j < ARRAY_N; j++) begin
        w_row[j] = pick_elem(jobs[k].use_lfsr, fix_w[j]);
        x_col[j] = pick_elem(jobs[k].use_lfsr, fix_x[j]);
      end
      // Z[i][j] gains X[i]*W[j] modulo 2^ACC_W
      for (int i = 0; i < ARRAY_N; i++) begin
        for (int j = 0; j < ARRAY_N; j++) begin
          model[i][j] = model[i][j] + acc_t'(int'(x_col[i]) * int'(w_row[j]));
        end
      end
      word.data = w_row;
      send_word(word, 1'b0, 1'b0);
      word.data = x_col;
      send_word(word, 1'b0, 1'b0);
    end
    exp_q.push_back(model);
    jobs_sent++;
  endtask

  task automatic receive_job(input int k);
    z_mat_t exp;
    int     r;
    r = 0;
    while (r < ARRAY_N) begin
      case (jobs[k].ready_mode)
        READY_ALWAYS: z_ready = 1'b1;
        READY_LFSR: begin
          ready_lfsr = galois_step(ready_lfsr);
          z_ready    = ready_lfsr[0];
        end
        // Stall after row 0 until all of the next job's input is in
        default: z_ready = (r == 0) || (jobs_sent >= k + 2);
      endcase
      #2;
      if (z_valid && z_ready) begin
        if (r == 0) begin
          if (exp_q.size() == 0) begin
            stop_with_failure("a result row arrived while no job was outstanding");
          end
          exp = exp_q.pop_front();
          if (!jobs[k].use_lfsr) begin
            check_row(z_beat.row, jobs[k].row0, $sformatf("job %0d table row 0", k));
          end
        end
        check_row(z_beat.row, exp[r], $sformatf("job %0d row %0d", k, r));
        check_flag(z_beat.last, (r == ARRAY_N - 1), $sformatf("job %0d row %0d last", k, r));
        r++;
        rows_seen++;
      end
      next_cycle();
    end
  endtask

  initial begin
    in_valid     = 1'b0;
    in_word      = '0;
    z_ready      = 1'b0;
    data_lfsr    = LfsrSeed;
    ready_lfsr   = LfsrSeed;
    jobs_sent    = 0;
    rows_seen    = 0;
    limit_cycles = watchdog_cycles();
    wait (rst_n === 1'b1);
    #2;
    check_flag(in_ready, 1'b1, "in_ready_o after reset");
    check_flag(z_valid, 1'b0, "z_valid_o after reset");
    check_flag(busy, 1'b0, "busy_o after reset");
    next_cycle();
    fork
      begin
        for (int k = 0; k < NumJobs; k++) begin
          drive_job(k);
        end
      end
      begin
        for (int k = 0; k < NumJobs; k++) begin
          receive_job(k);
        end
      end
    join
    #2;
    check_flag(z_valid, 1'b0, "z_valid_o after the final row");
    check_flag(busy, 1'b0, "busy_o after the final job");
    if ((rows_seen == NumJobs * ARRAY_N) && (exp_q.size() == 0)) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_with_failure("results were left over at the end of the run");
    end
  end

  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    stop_with_failure($sformatf("timeout, the jobs did not finish within %0d cycles",
                                limit_cycles));
  end

endmodule : redmule_tb

//--- filelist.f
logic/redmule_cfg_pkg.sv
logic/redmule_stream_pkg.sv
logic/redmule_stream_decoder.sv
logic/redmule_operand_fifo.sv
logic/redmule_engine.sv
logic/redmule_z_buffer.sv
logic/redmule_top.sv
verif/redmule_tb_clkgen.sv
verif/redmule_tb.sv

//--- Bender.yml
package:
  name: redmule_lite

sources:
  - logic/redmule_cfg_pkg.sv
  - logic/redmule_stream_pkg.sv
  - logic/redmule_stream_decoder.sv
  - logic/redmule_operand_fifo.sv
  - logic/redmule_engine.sv
  - logic/redmule_z_buffer.sv
  - logic/redmule_top.sv
  - target: test
    files:
      - verif/redmule_tb_clkgen.sv
      - verif/redmule_tb.sv
